// File: logic/xgmii_rx_pkg.sv
// ******************************
// xgmii rx package
// widths, XGMII control codes, MAC constants
// and the structs shared by the receive MAC
// ******************************
package xgmii_rx_pkg;

	typedef logic [63:0] xgmii_data_t;	// lane k is byte k
	typedef logic [7:0]  xgmii_ctrl_t;	// one control bit per lane
	typedef logic [47:0] mac_addr_t;	// 47:40 is first byte on the wire
	typedef logic [15:0] byte_cnt_t;
	typedef logic [31:0] stat_cnt_t;
	typedef logic [13:0] pkt_size_t;
	typedef logic [7:0]  lane_mask_t;

	// lane control characters
	localparam logic [7:0] XGMII_START = 8'hfb;
	localparam logic [7:0] XGMII_TERM  = 8'hfd;
	localparam logic [7:0] XGMII_ERROR = 8'hfe;

	localparam mac_addr_t   MAC_PAUSE_DA   = 48'h0180_c200_0001;
	localparam logic [15:0] ETYPE_MAC_CTRL = 16'h8808;
	localparam logic [15:0] PAUSE_OPCODE   = 16'h0001;
	localparam logic [24:0] MCAST_OUI      = {24'h01005e, 1'b0};	// ipv4 mcast prefix

	typedef struct packed {
		xgmii_data_t data;
		lane_mask_t  valid;
		logic        first;		// first data beat after start
		logic        last;		// terminate beat
		logic        link_err;
	} rx_beat_t;

	typedef struct packed {
		mac_addr_t station_addr;
		logic      bcast_en;
		logic      mcast_en;
		logic      pmode;
	} addr_cfg_t;

	typedef struct packed {
		logic accept;
		logic is_bcast;
		logic is_mcast;
		logic is_pause_da;
	} addr_verdict_t;

	typedef struct packed {
		stat_cnt_t link_err;
		stat_cnt_t oversize;
		stat_cnt_t bcast;
		stat_cnt_t mcast;
	} frame_counts_t;

	typedef struct packed {
		xgmii_data_t data;
		lane_mask_t  be;
		logic        start;
		logic        end_;
		logic        we;
	} pkt_beat_t;

endpackage

// File: logic/xgmii_lane_decoder.sv
// ******************************
// xgmii lane decoder
// registers the XGMII word, decodes start,
// terminate and error lanes and delimits frames
// ******************************
module xgmii_lane_decoder (
	input  logic                      clk156,
	input  logic                      rst_,
	input  logic                      rx_enable,
	input  xgmii_rx_pkg::xgmii_data_t rxd,
	input  xgmii_rx_pkg::xgmii_ctrl_t rxc,
	output xgmii_rx_pkg::rx_beat_t    beat
);
	import xgmii_rx_pkg::*;

	typedef enum logic {idle, in_frame} rx_state_t;

	rx_state_t   state;
	xgmii_data_t rxd_q;
	xgmii_ctrl_t rxc_q;
	lane_mask_t  is_term;
	lane_mask_t  is_err;
	lane_mask_t  data_mask;
	logic        term_seen;
	logic        is_start;
	logic        in_data;		// word belongs to the frame body
	logic        first_pend;

	always_ff @(posedge clk156)
	begin
		rxd_q <= rxd;
		rxc_q <= rxc;
	end

	// start only appears on lane 0 with aligned lanes
	assign is_start = rxc_q[0] && (rxd_q[7:0] == XGMII_START);
	assign in_data  = (state == in_frame) && !is_start;

	always_comb
	begin
		term_seen = 1'b0;
		for (int i = 0; i < 8; i++)
		begin
			is_term[i]   = rxc_q[i] && (rxd_q[8*i +: 8] == XGMII_TERM);
			is_err[i]    = rxc_q[i] && (rxd_q[8*i +: 8] == XGMII_ERROR);
			term_seen    = term_seen || is_term[i];
			data_mask[i] = !rxc_q[i] && !term_seen;	// lanes below terminate only
		end
	end

	always_ff @(posedge clk156)
	begin
		beat.data <= rxd_q;
		if (!rst_ || !rx_enable)
		begin
			state         <= idle;
			first_pend    <= 1'b0;
			beat.valid    <= '0;
			beat.first    <= 1'b0;
			beat.last     <= 1'b0;
			beat.link_err <= 1'b0;
		end
		else
		begin
			beat.valid    <= in_data ? data_mask : '0;
			beat.first    <= in_data && first_pend;
			beat.last     <= in_data && (|is_term);
			beat.link_err <= in_data && (|is_err);

			if (is_start)
			begin
				state      <= in_frame;
				first_pend <= 1'b1;	// next word is the first data beat
			end
			else if (state == in_frame)
			begin
				first_pend <= 1'b0;
				if (|is_term)
					state <= idle;
			end
		end
	end

endmodule

// File: logic/mac_addr_filter.sv
// ******************************
// destination address filter
// classifies the first beat and decides accept
// ******************************
module mac_addr_filter (
	input  logic                        clk156,
	input  logic                        rst_,
	input  xgmii_rx_pkg::rx_beat_t      beat,
	input  xgmii_rx_pkg::addr_cfg_t     cfg,
	output xgmii_rx_pkg::addr_verdict_t verdict,
	output logic                        verdict_vld
);
	import xgmii_rx_pkg::*;

	mac_addr_t da;
	logic      hit_station;
	logic      hit_bcast;
	logic      hit_mcast;
	logic      hit_pause;

	// lane 0 carries the first address byte
	assign da = {beat.data[7:0], beat.data[15:8], beat.data[23:16],
		beat.data[31:24], beat.data[39:32], beat.data[47:40]};

	assign hit_station = (da == cfg.station_addr);
	assign hit_bcast   = &da;
	assign hit_mcast   = (da[47:23] == MCAST_OUI);
	assign hit_pause   = (da == MAC_PAUSE_DA);

	always_ff @(posedge clk156)
	begin
		if (!rst_)
		begin
			verdict_vld <= 1'b0;
			verdict     <= '0;
		end
		else
		begin
			verdict_vld <= beat.first;
			if (beat.first)
			begin
				verdict.is_bcast    <= hit_bcast;
				verdict.is_mcast    <= hit_mcast;
				verdict.is_pause_da <= hit_pause;
				// pause frames are consumed by the MAC
				verdict.accept      <= !hit_pause && (hit_station || cfg.pmode ||
					(hit_bcast && cfg.bcast_en) || (hit_mcast && cfg.mcast_en));
			end
		end
	end

endmodule

// File: logic/pause_frame_detect.sv
// ******************************
// pause frame detect
// picks ethertype, opcode and quanta and
// holds the pause request until acknowledged
// ******************************
module pause_frame_detect (
	input  logic                        clk156,
	input  logic                        rst_,
	input  xgmii_rx_pkg::rx_beat_t      beat,
	input  xgmii_rx_pkg::addr_verdict_t verdict,
	input  logic                        pause_en,
	input  logic                        rx_pack,
	output logic                        rx_pause,
	output logic [15:0]                 rx_pvalue
);
	import xgmii_rx_pkg::*;

	logic [1:0]  beat_idx;		// saturates at 3
	logic [15:0] etype;
	logic [15:0] opcode;
	logic [15:0] quanta;
	logic        err_q;
	logic        frame_err;
	logic        pause_hit;

	assign frame_err = (err_q && !beat.first) || beat.link_err;

	always_ff @(posedge clk156)
	begin
		if ((|beat.valid) && !beat.first && (beat_idx == 2'd1))
		begin
			etype  <= {beat.data[39:32], beat.data[47:40]};	// lane 4 high byte
			opcode <= {beat.data[55:48], beat.data[63:56]};
		end
		if ((|beat.valid) && (beat_idx == 2'd2))
			quanta <= {beat.data[7:0], beat.data[15:8]};
		if (pause_hit)
			rx_pvalue <= quanta;
	end

	always_ff @(posedge clk156)
	begin
		if (!rst_)
		begin
			beat_idx  <= 2'd3;
			err_q     <= 1'b0;
			pause_hit <= 1'b0;
			rx_pause  <= 1'b0;
		end
		else
		begin
			if (beat.first)
				beat_idx <= 2'd1;
			else if ((|beat.valid) && (beat_idx != 2'd3))
				beat_idx <= beat_idx + 2'd1;

			err_q     <= frame_err;
			pause_hit <= beat.last && verdict.is_pause_da && pause_en && !frame_err &&
				(etype == ETYPE_MAC_CTRL) && (opcode == PAUSE_OPCODE);
			rx_pause  <= rx_pause ? !rx_pack : pause_hit;	// held until ack
		end
	end

endmodule

// File: logic/rx_frame_stats.sv
// ******************************
// rx frame statistics
// byte count per frame, oversize check and
// the event counters with clear
// ******************************
module rx_frame_stats (
	input  logic                        clk156,
	input  logic                        rst_,
	input  xgmii_rx_pkg::rx_beat_t      beat,
	input  xgmii_rx_pkg::addr_verdict_t verdict,
	input  xgmii_rx_pkg::pkt_size_t     max_pkt_size,
	input  logic                        stat_clr,
	output xgmii_rx_pkg::byte_cnt_t     nbytes,
	output logic                        nbytes_vld,
	output xgmii_rx_pkg::frame_counts_t counts
);
	import xgmii_rx_pkg::*;

	byte_cnt_t  acc;
	byte_cnt_t  frame_bytes;
	logic [3:0] lane_cnt;
	logic       err_q;
	logic       frame_err;
	logic       oversize;

	function automatic logic [3:0] count_lanes(input lane_mask_t m);
		logic [3:0] n;
		n = 4'd0;
		for (int i = 0; i < 8; i++)
			n = n + {3'b000, m[i]};
		return n;
	endfunction

	assign lane_cnt    = count_lanes(beat.valid);
	assign frame_bytes = (beat.first ? 16'h0000 : acc) + {12'h000, lane_cnt};
	assign frame_err   = (err_q && !beat.first) || beat.link_err;
	assign oversize    = frame_bytes > {2'b00, max_pkt_size};	// includes fcs

	always_ff @(posedge clk156)
	begin
		if (beat.last)
			nbytes <= frame_bytes;
	end

	always_ff @(posedge clk156)
	begin
		if (!rst_)
		begin
			acc        <= '0;
			err_q      <= 1'b0;
			nbytes_vld <= 1'b0;
			counts     <= '0;
		end
		else
		begin
			acc        <= frame_bytes;	// idle beats add nothing
			err_q      <= frame_err;
			nbytes_vld <= beat.last;

			// clear beats a same-cycle increment
			if (stat_clr)
				counts <= '0;
			else if (beat.last)
			begin
				counts.link_err <= counts.link_err + {31'd0, frame_err};
				counts.oversize <= counts.oversize + {31'd0, oversize};
				counts.bcast    <= counts.bcast + {31'd0, verdict.is_bcast};
				counts.mcast    <= counts.mcast + {31'd0, verdict.is_mcast};
			end
		end
	end

endmodule

// File: logic/rx_pkt_stream.sv
// ******************************
// rx packet stream
// holds beats until the address verdict and
// emits accepted frames with byte enables
// ******************************
module rx_pkt_stream (
	input  logic                        clk156,
	input  logic                        rst_,
	input  logic                        rx_enable,
	input  xgmii_rx_pkg::rx_beat_t      beat,
	input  xgmii_rx_pkg::addr_verdict_t verdict,
	input  logic                        verdict_vld,
	output xgmii_rx_pkg::pkt_beat_t     pkt
);
	import xgmii_rx_pkg::*;

	rx_beat_t s1;			// one beat behind the decoder
	logic     acc_q;
	logic     accept_now;
	logic     s1_bytes;
	logic     next_empty_term;

	// verdict lines up with the first beat in s1
	assign accept_now      = verdict_vld ? verdict.accept : acc_q;
	assign s1_bytes        = |s1.valid;
	assign next_empty_term = beat.last && !(|beat.valid);	// terminate on lane 0

	always_ff @(posedge clk156)
	begin
		pkt.data <= s1.data;
		pkt.be   <= s1.valid;
	end

	always_ff @(posedge clk156)
	begin
		if (!rst_ || !rx_enable)
		begin
			s1.valid  <= '0;
			s1.first  <= 1'b0;
			s1.last   <= 1'b0;
			acc_q     <= 1'b0;
			pkt.start <= 1'b0;
			pkt.end_  <= 1'b0;
			pkt.we    <= 1'b0;
		end
		else
		begin
			s1        <= beat;
			acc_q     <= accept_now;
			pkt.we    <= accept_now && s1_bytes;
			pkt.start <= accept_now && s1.first;
			// end lands on the last beat that carries bytes
			pkt.end_  <= accept_now && s1_bytes && (s1.last || next_empty_term);
		end
	end

endmodule

// File: logic/xgmii_rx_mac.sv
// ******************************
// 10G receive MAC top
// XGMII decode, address filter, pause,
// statistics and packet stream
// ******************************
module xgmii_rx_mac (
	input  logic                        clk156,
	input  logic                        rst_,
	input  logic                        rx_enable,
	input  xgmii_rx_pkg::xgmii_data_t   rxd,
	input  xgmii_rx_pkg::xgmii_ctrl_t   rxc,
	input  xgmii_rx_pkg::addr_cfg_t     cfg,
	input  logic                        pause_en,
	input  xgmii_rx_pkg::pkt_size_t     max_pkt_size,
	input  logic                        rx_pack,
	input  logic                        stat_clr,
	output xgmii_rx_pkg::pkt_beat_t     pkt,
	output logic                        rx_pause,
	output logic [15:0]                 rx_pvalue,
	output xgmii_rx_pkg::byte_cnt_t     nbytes,
	output logic                        nbytes_vld,
	output xgmii_rx_pkg::frame_counts_t counts
);
	import xgmii_rx_pkg::*;

	rx_beat_t      beat;
	addr_verdict_t verdict;
	logic          verdict_vld;

	xgmii_lane_decoder u_decoder (
		.clk156    (clk156),
		.rst_      (rst_),
		.rx_enable (rx_enable),
		.rxd       (rxd),
		.rxc       (rxc),
		.beat      (beat)
	);

	mac_addr_filter u_filter (
		.clk156      (clk156),
		.rst_        (rst_),
		.beat        (beat),
		.cfg         (cfg),
		.verdict     (verdict),
		.verdict_vld (verdict_vld)
	);

	pause_frame_detect u_pause (
		.clk156    (clk156),
		.rst_      (rst_),
		.beat      (beat),
		.verdict   (verdict),
		.pause_en  (pause_en),
		.rx_pack   (rx_pack),
		.rx_pause  (rx_pause),
		.rx_pvalue (rx_pvalue)
	);

	rx_frame_stats u_stats (
		.clk156       (clk156),
		.rst_         (rst_),
		.beat         (beat),
		.verdict      (verdict),
		.max_pkt_size (max_pkt_size),
		.stat_clr     (stat_clr),
		.nbytes       (nbytes),
		.nbytes_vld   (nbytes_vld),
		.counts       (counts)
	);

	rx_pkt_stream u_stream (
		.clk156      (clk156),
		.rst_        (rst_),
		.rx_enable   (rx_enable),
		.beat        (beat),
		.verdict     (verdict),
		.verdict_vld (verdict_vld),
		.pkt         (pkt)
	);

endmodule

// File: sim/tb_clock.sv
// ******************************
// testbench clock and reset
// ******************************
module tb_clock (
	output logic clk156,
	output logic rst_
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk156 = 1'b0;
		forever
			#5 clk156 = ~clk156;
	end

	initial
	begin
		rst_ = 1'b0;
		repeat (4) @(posedge clk156);	// 4 cycles of reset
		#1 rst_ = 1'b1;
	end

endmodule

// File: sim/xgmii_rx_checker.sv
// ******************************
// receive MAC checker
// expected stream, byte counts, counters
// and pause request, compared every cycle
// ******************************
module xgmii_rx_checker (
	input  logic                        clk156,
	input  logic                        rst_,
	input  xgmii_rx_pkg::pkt_beat_t     pkt,
	input  logic                        rx_pause,
	input  logic [15:0]                 rx_pvalue,
	input  xgmii_rx_pkg::byte_cnt_t     nbytes,
	input  logic                        nbytes_vld,
	input  xgmii_rx_pkg::frame_counts_t counts,
	input  logic                        rx_pack,
	input  logic                        stat_clr
);
	timeunit 1ns;
	timeprecision 100ps;
	import xgmii_rx_pkg::*;

	typedef struct packed {
		byte_cnt_t   len;
		logic        pause;
		logic [15:0] quanta;
		logic        bcast;
		logic        mcast;
		logic        err;
		logic        over;
	} frame_rec_t;

	frame_rec_t    rec_q[$];
	pkt_beat_t     beat_q[$];
	frame_rec_t    rec_now;
	pkt_beat_t     beat_now;
	frame_counts_t exp_counts;
	logic          exp_pause;
	logic [15:0]   exp_pvalue;
	logic          hit_q;
	logic [15:0]   hit_quanta;
	logic          clr_q;
	logic          pack_q;
	logic          in_pkt;
	int            errors;
	int            frames_seen;
	int            beats_seen;

	initial
	begin
		exp_counts = '0;
		exp_pause  = 1'b0;
		exp_pvalue = '0;
		hit_q      = 1'b0;
		hit_quanta = '0;
		clr_q      = 1'b0;
		pack_q     = 1'b0;
		in_pkt     = 1'b0;
		errors     = 0;
		frames_seen = 0;
		beats_seen = 0;
	end

	function automatic void compare(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endfunction

	function automatic void report_failure(input string what);
		errors++;
		$display("%0t: %s", $time, what);
	endfunction

	function automatic logic [63:0] lane_bits(input lane_mask_t m);
		logic [63:0] v;
		for (int j = 0; j < 8; j++)
			v[8*j +: 8] = {8{m[j]}};
		return v;
	endfunction

	// called by the driver for each frame before it goes on the wire
	task automatic add_frame(input addr_cfg_t cfg, input logic pause_en,
		input pkt_size_t max_size, input mac_addr_t da, input logic [15:0] etype,
		input logic [15:0] opcode, input logic [15:0] quanta, input int len,
		input int err_lane, input logic [1023:0] bytes);
		frame_rec_t rec;
		pkt_beat_t  b;
		logic       accept;
		int         nb;
		rec.len    = len;
		rec.bcast  = &da;
		rec.mcast  = (da[47:23] == MCAST_OUI);
		rec.err    = (err_lane >= 0);
		rec.over   = (len > max_size);
		rec.quanta = quanta;
		rec.pause  = (da == MAC_PAUSE_DA) && (etype == ETYPE_MAC_CTRL) &&
			(opcode == PAUSE_OPCODE) && pause_en && !rec.err;
		accept = (da != MAC_PAUSE_DA) && ((da == cfg.station_addr) || cfg.pmode ||
			(rec.bcast && cfg.bcast_en) || (rec.mcast && cfg.mcast_en));
		rec_q.push_back(rec);
		nb = (len + 7) / 8;
		for (int i = 0; accept && (i < nb); i++)
		begin
			b       = '0;
			b.we    = 1'b1;
			b.start = (i == 0);
			b.end_  = (i == nb - 1);
			for (int j = 0; j < 8; j++)
				if (8*i + j < len)
				begin
					b.data[8*j +: 8] = bytes[8*(8*i + j) +: 8];
					b.be[j]          = 1'b1;
				end
			beat_q.push_back(b);
		end
	endtask

	always @(negedge clk156)
	begin
		if (rst_)
		begin
			// pause request follows the terminate by one cycle after the count
			exp_pause = exp_pause ? !pack_q : hit_q;
			if (hit_q)
				exp_pvalue = hit_quanta;
			hit_q = 1'b0;
			if (nbytes_vld)
			begin
				if (rec_q.size() == 0)
					report_failure("frame length reported with no frame outstanding");
				else
				begin
					rec_now = rec_q.pop_front();
					frames_seen++;
					compare("nbytes", nbytes, rec_now.len);
					exp_counts.link_err = exp_counts.link_err + {31'd0, rec_now.err};
					exp_counts.oversize = exp_counts.oversize + {31'd0, rec_now.over};
					exp_counts.bcast    = exp_counts.bcast + {31'd0, rec_now.bcast};
					exp_counts.mcast    = exp_counts.mcast + {31'd0, rec_now.mcast};
					hit_q      = rec_now.pause;
					hit_quanta = rec_now.quanta;
				end
			end
			if (clr_q)
				exp_counts = '0;
			compare("counts.link_err", counts.link_err, exp_counts.link_err);
			compare("counts.oversize", counts.oversize, exp_counts.oversize);
			compare("counts.bcast", counts.bcast, exp_counts.bcast);
			compare("counts.mcast", counts.mcast, exp_counts.mcast);
			compare("rx_pause", rx_pause, exp_pause);
			if (exp_pause)
				compare("rx_pvalue", rx_pvalue, exp_pvalue);

			if (pkt.we)
			begin
				if (beat_q.size() == 0)
					report_failure("stream beat seen for a frame that should be dropped");
				else
				begin
					beat_now = beat_q.pop_front();
					beats_seen++;
					compare("pkt.be", pkt.be, beat_now.be);
					compare("pkt.data", pkt.data & lane_bits(beat_now.be), beat_now.data);
					compare("pkt.start", pkt.start, beat_now.start);
					compare("pkt.end_", pkt.end_, beat_now.end_);
				end
				in_pkt = !pkt.end_;
			end
			else
			begin
				if (in_pkt)
					report_failure("stream gap inside a frame");
				if (pkt.start || pkt.end_)
					report_failure("start or end_ raised without we");
				in_pkt = 1'b0;
			end
			clr_q  = stat_clr;
			pack_q = rx_pack;
		end
	end

	function automatic int pending();
		return rec_q.size() + beat_q.size();
	endfunction

	function automatic int final_report();
		if (pending() != 0)
			report_failure("frames or beats still expected at the end of the run");
		$display("frames %0d, beats %0d, errors %0d", frames_seen, beats_seen, errors);
		return errors;
	endfunction

endmodule

// File: sim/xgmii_rx_tb.sv
// ******************************
// receive MAC testbench
// reads frame descriptors, drives XGMII words
// and acknowledges pause requests
// ******************************
module xgmii_rx_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import xgmii_rx_pkg::*;

	localparam int GAP_WORDS = 4;

	logic          clk156;
	logic          rst_;
	logic          rx_enable;
	xgmii_data_t   rxd;
	xgmii_ctrl_t   rxc;
	addr_cfg_t     cfg;
	logic          pause_en;
	pkt_size_t     max_pkt_size;
	logic          rx_pack;
	logic          stat_clr;
	pkt_beat_t     pkt;
	logic          rx_pause;
	logic [15:0]   rx_pvalue;
	byte_cnt_t     nbytes;
	logic          nbytes_vld;
	frame_counts_t counts;
	logic [31:0]   lfsr_state;
	string         lines[$];
	int            limit;
	int            errs;

	tb_clock clkgen (.clk156(clk156), .rst_(rst_));

	xgmii_rx_mac UUT (
		.clk156(clk156), .rst_(rst_), .rx_enable(rx_enable), .rxd(rxd), .rxc(rxc),
		.cfg(cfg), .pause_en(pause_en), .max_pkt_size(max_pkt_size), .rx_pack(rx_pack),
		.stat_clr(stat_clr), .pkt(pkt), .rx_pause(rx_pause), .rx_pvalue(rx_pvalue),
		.nbytes(nbytes), .nbytes_vld(nbytes_vld), .counts(counts)
	);

	xgmii_rx_checker chk (
		.clk156(clk156), .rst_(rst_), .pkt(pkt), .rx_pause(rx_pause),
		.rx_pvalue(rx_pvalue), .nbytes(nbytes), .nbytes_vld(nbytes_vld),
		.counts(counts), .rx_pack(rx_pack), .stat_clr(stat_clr)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] v;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	function automatic int frame_words(input string line);
		logic [47:0] da;
		logic [15:0] f;
		int          len;
		int          n;
		n = $sscanf(line, "FRM %h %h %h %h %d", da, f, f, f, len);
		return (n >= 5) ? len / 8 + 2 + GAP_WORDS : 0;
	endfunction

	task automatic drive_word(input xgmii_data_t d, input xgmii_ctrl_t c);
		@(posedge clk156);
		#1;
		rxd = d;
		rxc = c;
	endtask

	task automatic apply_config(input string line);
		logic [47:0] sa;
		logic        b_en;
		logic        m_en;
		logic        pm;
		logic        pe;
		logic [13:0] mx;
		int          n;
		n = $sscanf(line, "CFG %h %h %h %h %h %h", sa, b_en, m_en, pm, pe, mx);
		if (n != 6)
			chk.report_failure("malformed CFG line in the input file");
		cfg.station_addr = sa;
		cfg.bcast_en     = b_en;
		cfg.mcast_en     = m_en;
		cfg.pmode        = pm;
		pause_en         = pe;
		max_pkt_size     = mx;
	endtask

	task automatic clear_stats();
		@(posedge clk156);
		#1 stat_clr = 1'b1;
		@(posedge clk156);
		#1 stat_clr = 1'b0;
	endtask

	task automatic send_frame(input string line);
		mac_addr_t     da;
		logic [15:0]   et;
		logic [15:0]   op;
		logic [15:0]   q;
		int            len;
		int            errl;
		int            k;
		int            n;
		logic [1023:0] fb;
		xgmii_data_t   d;
		xgmii_ctrl_t   c;
		errl = -1;	// error lane is optional
		n    = $sscanf(line, "FRM %h %h %h %h %d %d", da, et, op, q, len, errl);
		if (n < 5)
		begin
			chk.report_failure("malformed FRM line in the input file");
			return;
		end
		fb = '0;
		for (int i = 0; i < 6; i++)
		begin
			fb[8*i +: 8]     = da[47 - 8*i -: 8];	// first wire byte on lane 0
			fb[8*(6+i) +: 8] = 8'h20 + i[7:0];		// source address
		end
		fb[143:96] = {q[7:0], q[15:8], op[7:0], op[15:8], et[7:0], et[15:8]};
		for (int i = 18; i < len; i++)
			fb[8*i +: 8] = random_byte();
		chk.add_frame(cfg, pause_en, max_pkt_size, da, et, op, q, len, errl, fb);
		drive_word(64'hd555_5555_5555_55fb, 8'h01);
		for (int w = 0; w < len / 8; w++)
			drive_word(fb[64*w +: 64], 8'h00);
		k = len % 8;
		for (int j = 0; j < 8; j++)
		begin
			c[j] = (j >= k);
			if (j < k)
				d[8*j +: 8] = fb[64*(len/8) + 8*j +: 8];
			else if (j == k)
				d[8*j +: 8] = XGMII_TERM;
			else
				d[8*j +: 8] = (j == errl) ? XGMII_ERROR : 8'h07;
		end
		drive_word(d, c);
		repeat (GAP_WORDS) drive_word({8{8'h07}}, 8'hff);
	endtask

	task automatic run_watchdog(input int cycles);
		repeat (cycles) @(posedge clk156);
		$display("timeout: run did not finish within %0d cycles", cycles);
		$display("CHECKS FAILED");
		$finish;
	endtask

	// pause ack a few cycles after the request
	initial
	begin
		rx_pack = 1'b0;
		forever
		begin
			@(posedge clk156);
			#1;
			if (rx_pause)
			begin
				repeat (4) @(posedge clk156);
				#1 rx_pack = 1'b1;
				@(posedge clk156);
				#1 rx_pack = 1'b0;
			end
		end
	end

	initial
	begin
		int    fd;
		int    beats;
		string line;
		string kw;
		rx_enable    = 1'b0;
		rxd          = {8{8'h07}};
		rxc          = 8'hff;
		cfg          = '0;
		pause_en     = 1'b0;
		max_pkt_size = '0;
		stat_clr     = 1'b0;
		lfsr_state   = 32'hc79f_3bf9;
		beats        = 0;
		fd = $fopen("sim/xgmii_rx_input.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open sim/xgmii_rx_input.txt");
			$display("CHECKS FAILED");
			$finish;
		end
		else
		begin
			while ($fgets(line, fd))
			begin
				kw = line.substr(0, 2);
				if (kw == "FRM")
					beats += frame_words(line);
				else if (kw == "CLR")
					beats += 2;
				lines.push_back(line);
			end
			$fclose(fd);
			limit = 2 * beats + 1000;
			fork
				run_watchdog(limit);
			join_none
			@(posedge rst_);
			repeat (2) @(posedge clk156);
			#1 rx_enable = 1'b1;
			foreach (lines[i])
			begin
				kw = lines[i].substr(0, 2);
				if (kw == "CFG")
					apply_config(lines[i]);
				else if (kw == "FRM")
					send_frame(lines[i]);
				else if (kw == "CLR")
					clear_stats();
			end
			while ((chk.pending() != 0) || rx_pause)
				@(posedge clk156);
			repeat (4) @(posedge clk156);
			errs = chk.final_report();
			if (errs == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

// File: xgmii_rx.f
logic/xgmii_rx_pkg.sv
logic/xgmii_lane_decoder.sv
logic/mac_addr_filter.sv
logic/pause_frame_detect.sv
logic/rx_frame_stats.sv
logic/rx_pkt_stream.sv
logic/xgmii_rx_mac.sv
sim/tb_clock.sv
sim/xgmii_rx_checker.sv
sim/xgmii_rx_tb.sv

// File: sim/xgmii_rx_input.txt
# CFG station_addr bcast_en mcast_en pmode pause_en max_pkt_size   (all hex)
# FRM dest_addr ethertype opcode quanta length error_lane   (length and error_lane decimal, -1 none)
CFG 0a1b2c3d4e5f 1 1 0 1 0040
FRM 0a1b2c3d4e5f 0800 0000 0000 24 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 25 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 26 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 27 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 28 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 29 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 30 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 31 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 72 -1
FRM ffffffffffff 0800 0000 0000 40 -1
FRM 01005e0a0b0c 0800 0000 0000 33 -1
FRM 0a1b2c3d4e00 0800 0000 0000 36 -1
FRM 0180c2000001 8808 0001 1234 60 -1
FRM 0a1b2c3d4e5f 0800 0000 0000 34 5
FRM 0180c2000001 8808 0001 5555 42 6
CFG 0a1b2c3d4e5f 0 0 0 0 0040
FRM ffffffffffff 0800 0000 0000 40 -1
FRM 01005e0a0b0c 0800 0000 0000 33 -1
FRM 0180c2000001 8808 0001 0777 60 -1
CLR
CFG 0a1b2c3d4e5f 0 0 1 1 0040
FRM 0a1b2c3d4e00 0800 0000 0000 45 -1
FRM 01005e0a0b0c 0800 0000 0000 48 -1
FRM 0180c2000001 8808 0001 00ff 64 -1
